/* include/ldu_cfg.svh */
`ifndef LDU_CFG_SVH
`define LDU_CFG_SVH

// --------------------------------------------------
// register file banking

`define LDU_PRF_BANK_COUNT 4
`define LDU_LOG_PRF_BANK_COUNT $clog2(`LDU_PRF_BANK_COUNT)

// --------------------------------------------------
// completion queue

`define LDU_CQ_ENTRIES 16
`define LDU_LOG_CQ_ENTRIES $clog2(`LDU_CQ_ENTRIES)

// --------------------------------------------------
// virtual address split, 4 KiB pages

`define LDU_VPN_WIDTH 20
`define LDU_PO_WIDTH 12

// word address bit that picks the dcache bank
`define LDU_DCACHE_BANK_BIT 0

`endif

/* project.f */
+incdir+include
verilog/ldu_types_pkg.sv
verilog/ldu_operand_collect.sv
verilog/ldu_req_stage.sv
verilog/ldu_addr_pipeline.sv
tb/tb_ldu_addr_pipeline.sv

/* tb/ldu_tests.txt */
// op imm src(0 zero,1 fwd,2 reg) bank port A cq ready_dly beats
//   then per beat: bank vpn po_word mask mq (second beat zero when unused)
// aligned byte, halfword, word loads
0 004 0 0 0 00000000 0 0 1  1 00000 001 1 0  0 0 0 0 0
4 013 1 1 0 12345000 1 1 1  0 12345 004 8 0  0 0 0 0 0
1 002 1 2 0 0000a100 2 0 1  0 0000a 040 c 0  0 0 0 0 0
5 7fe 0 0 0 00000000 3 0 1  1 00000 1ff c 0  0 0 0 0 0
2 008 1 3 0 80001000 4 2 1  0 80001 002 f 0  0 0 0 0 0
// register ack in first OC cycle, negative immediate
2 ffc 2 0 1 00003010 5 0 1  1 00003 003 f 0  0 0 0 0 0
// split loads
2 021 1 1 0 00005000 6 1 2  0 00005 008 e 0  1 00005 009 1 1
1 00b 0 0 0 00000000 7 0 2  0 00000 002 8 0  1 00000 003 1 1
1 001 1 0 0 00020000 8 0 1  0 00020 000 6 0  0 0 0 0 0
2 00f 2 2 0 00007ff0 9 0 2  1 00007 3ff 8 0  0 00008 000 7 1
// long stall, register ack lands during the stall
0 010 1 3 0 00010000 a 6 1  0 00010 004 1 0  0 0 0 0 0
2 104 2 1 1 00042000 b 0 1  1 00042 041 f 0  0 0 0 0 0
// OC full under back-pressure
4 803 0 0 0 00000000 c 3 1  0 fffff 200 8 0  0 0 0 0 0
5 000 1 2 0 00100ffe d 0 1  1 00100 3ff c 0  0 0 0 0 0
2 006 1 0 0 dead0000 e 2 2  1 dead0 001 c 0  0 dead0 002 3 1
0 f00 2 3 0 00000100 f 1 1  0 00000 000 1 0  0 0 0 0 0
// queue index wraps
2 010 0 0 0 00000000 0 0 1  0 00000 004 f 0  0 0 0 0 0
1 003 2 0 0 00003000 1 4 2  0 00003 000 8 0  1 00003 001 1 1
4 001 1 1 0 fffff004 2 0 1  1 fffff 001 2 0  0 0 0 0 0
2 7fc 2 2 1 0abcd018 3 0 1  1 0abcd 205 f 0  0 0 0 0 0

/* tb/tb_ldu_addr_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ldu_addr_pipeline;

    import ldu_types_pkg::*;

    localparam int NUM_TESTS  = 20;
    localparam int NUM_FIELDS = 19;

    // field positions within one test line
    localparam int F_OP    = 0;
    localparam int F_IMM   = 1;
    localparam int F_SRC   = 2;
    localparam int F_BANK  = 3;
    localparam int F_PORT  = 4;
    localparam int F_A     = 5;
    localparam int F_CQ    = 6;
    localparam int F_DLY   = 7;
    localparam int F_BEATS = 8;
    localparam int F_BEAT0 = 9;

    logic            CLK;
    logic            nRST;
    logic            issue_valid;
    ldu_op_t         issue_op;
    imm12_t          issue_imm12;
    logic            issue_A_forward;
    logic            issue_A_is_zero;
    prf_bank_t       issue_A_bank;
    cq_index_t       issue_cq_index;
    logic            issue_ready;
    logic            A_reg_read_ack;
    logic            A_reg_read_port;
    bank_port_data_t reg_read_data_by_bank_by_port;
    bank_data_t      forward_data_by_bank;
    logic            req_bank0_valid;
    logic            req_bank1_valid;
    logic            req_is_mq;
    logic            req_misaligned;
    vpn_t            req_vpn;
    po_word_t        req_po_word;
    byte_mask_t      req_byte_mask;
    cq_index_t       req_cq_index;
    logic            req_bank0_early_ready;
    logic            req_bank1_early_ready;

    logic [31:0] tests [0:NUM_TESTS*NUM_FIELDS-1];
    integer      seed = 32'h6ed957d3;
    integer      ack_seed;
    integer      full_stalls;

    ldu_addr_pipeline uut (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] field(input integer t, input integer f);
        return tests[t*NUM_FIELDS + f];
    endfunction

    // --------------------------------------------------
    // compare tasks

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input vpn_t exp, input vpn_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_index(input string name, input cq_index_t exp, input cq_index_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_mask(input string name, input byte_mask_t exp, input byte_mask_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // one request beat against its data-file line
    task automatic check_beat(input integer t, input integer b);
        integer base;
        base = F_BEAT0 + b*5;
        check_flag("req_bank0_valid", field(t, base) == 0, req_bank0_valid);
        check_flag("req_bank1_valid", field(t, base) == 1, req_bank1_valid);
        check_word("req_vpn", vpn_t'(field(t, base+1)), req_vpn);
        check_word("req_po_word", vpn_t'(field(t, base+2)), vpn_t'(req_po_word));
        check_mask("req_byte_mask", byte_mask_t'(field(t, base+3)), req_byte_mask);
        check_flag("req_is_mq", field(t, base+4) != 0, req_is_mq);
        check_flag("req_misaligned", field(t, F_BEATS) == 2, req_misaligned);
        check_index("req_cq_index", cq_index_t'(field(t, F_CQ)), req_cq_index);
    endtask

    // --------------------------------------------------
    // issue queue and register file model

    task automatic run_issue;
        integer t;
        integer k;
        for (t = 0; t < NUM_TESTS; t++) begin
            issue_valid     <= 1'b1;
            issue_op        <= ldu_op_t'(field(t, F_OP));
            issue_imm12     <= imm12_t'(field(t, F_IMM));
            issue_A_is_zero <= field(t, F_SRC) == 0;
            issue_A_forward <= field(t, F_SRC) == 1;
            issue_A_bank    <= prf_bank_t'(field(t, F_BANK));
            issue_cq_index  <= cq_index_t'(field(t, F_CQ));
            @(negedge CLK);
            while (!issue_ready) begin
                full_stalls = full_stalls + 1;
                @(negedge CLK);
            end
            // accepted on this edge
            @(posedge CLK);
            if (field(t, F_SRC) == 1) begin
                forward_data_by_bank[field(t, F_BANK)] <= field(t, F_A);
            end else if (field(t, F_SRC) == 2) begin
                issue_valid <= 1'b0;
                reg_read_data_by_bank_by_port[field(t, F_BANK)][field(t, F_PORT)]
                    <= field(t, F_A);
                A_reg_read_port <= field(t, F_PORT) != 0;
                k = $random(ack_seed) & 32'h1;
                repeat (k) @(posedge CLK);
                A_reg_read_ack <= 1'b1;
                @(posedge CLK);
                A_reg_read_ack <= 1'b0;
            end
        end
        issue_valid <= 1'b0;
    endtask

    // --------------------------------------------------
    // dcache bank model, takes beats in order

    task automatic run_monitor;
        integer t;
        integer b;
        integer d;
        integer k;
        for (t = 0; t < NUM_TESTS; t++) begin
            for (b = 0; b < field(t, F_BEATS); b++) begin
                @(negedge CLK);
                while (!(req_bank0_valid || req_bank1_valid)) @(negedge CLK);
                check_beat(t, b);
                d = field(t, F_DLY) + ($random(seed) & 32'h1);
                // beat must hold while banks are busy
                for (k = 0; k < d; k++) begin
                    @(negedge CLK);
                    check_beat(t, b);
                end
                @(posedge CLK);
                req_bank0_early_ready <= 1'b1;
                req_bank1_early_ready <= 1'b1;
                @(negedge CLK);
                check_beat(t, b);
                @(posedge CLK);
                req_bank0_early_ready <= 1'b0;
                req_bank1_early_ready <= 1'b0;
            end
        end
    endtask

    // --------------------------------------------------
    // main sequence

    initial begin
        nRST                          = 1'b0;
        issue_valid                   = 1'b0;
        issue_op                      = LB;
        issue_imm12                   = '0;
        issue_A_forward               = 1'b0;
        issue_A_is_zero               = 1'b0;
        issue_A_bank                  = '0;
        issue_cq_index                = '0;
        A_reg_read_ack                = 1'b0;
        A_reg_read_port               = 1'b0;
        reg_read_data_by_bank_by_port = '0;
        forward_data_by_bank          = '0;
        req_bank0_early_ready         = 1'b0;
        req_bank1_early_ready         = 1'b0;
        full_stalls                   = 0;
        ack_seed                      = seed + 1;

        $readmemh("tb/ldu_tests.txt", tests);

        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_flag("req_bank0_valid", 1'b0, req_bank0_valid);
        check_flag("req_bank1_valid", 1'b0, req_bank1_valid);
        check_flag("req_is_mq", 1'b0, req_is_mq);
        check_flag("issue_ready", 1'b1, issue_ready);
        @(posedge CLK);

        fork
            run_issue();
            run_monitor();
        join

        // nothing left over after the last beat
        repeat (5) begin
            @(negedge CLK);
            check_flag("req_bank0_valid", 1'b0, req_bank0_valid);
            check_flag("req_bank1_valid", 1'b0, req_bank1_valid);
        end
        if (full_stalls == 0) begin
            report_error("issue_ready never dropped while OC and REQ were both full");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS*40 + 20) @(posedge CLK);
        $display("run timed out before all expected beats were seen");
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* verilog/ldu_addr_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module ldu_addr_pipeline (
    input  wire logic                          CLK,
    input  wire logic                          nRST,

    // issue queue side
    input  wire logic                          issue_valid,
    input  ldu_types_pkg::ldu_op_t             issue_op,
    input  ldu_types_pkg::imm12_t              issue_imm12,
    input  wire logic                          issue_A_forward,
    input  wire logic                          issue_A_is_zero,
    input  ldu_types_pkg::prf_bank_t           issue_A_bank,
    input  ldu_types_pkg::cq_index_t           issue_cq_index,
    output logic                               issue_ready,

    // register file read and forward data
    input  wire logic                          A_reg_read_ack,
    input  wire logic                          A_reg_read_port,
    input  ldu_types_pkg::bank_port_data_t     reg_read_data_by_bank_by_port,
    input  ldu_types_pkg::bank_data_t          forward_data_by_bank,

    // dcache request
    output logic                               req_bank0_valid,
    output logic                               req_bank1_valid,
    output logic                               req_is_mq,
    output logic                               req_misaligned,
    output ldu_types_pkg::vpn_t                req_vpn,
    output ldu_types_pkg::po_word_t            req_po_word,
    output ldu_types_pkg::byte_mask_t          req_byte_mask,
    output ldu_types_pkg::cq_index_t           req_cq_index,
    input  wire logic                          req_bank0_early_ready,
    input  wire logic                          req_bank1_early_ready
);

    import ldu_types_pkg::*;

    // --------------------------------------------------
    // OC to REQ handoff

    logic       next_req_valid;
    ldu_op_t    next_req_op;
    imm12_t     next_req_imm12;
    word_t      next_req_A;
    cq_index_t  next_req_cq_index;
    logic       stall_req;

    ldu_operand_collect u_oc (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .issue_valid                   (issue_valid),
        .issue_op                      (issue_op),
        .issue_imm12                   (issue_imm12),
        .issue_A_forward               (issue_A_forward),
        .issue_A_is_zero               (issue_A_is_zero),
        .issue_A_bank                  (issue_A_bank),
        .issue_cq_index                (issue_cq_index),
        .issue_ready                   (issue_ready),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .stall_req                     (stall_req),
        .next_req_valid                (next_req_valid),
        .next_req_op                   (next_req_op),
        .next_req_imm12                (next_req_imm12),
        .next_req_A                    (next_req_A),
        .next_req_cq_index             (next_req_cq_index)
    );

    ldu_req_stage u_req (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .next_req_valid        (next_req_valid),
        .next_req_op           (next_req_op),
        .next_req_imm12        (next_req_imm12),
        .next_req_A            (next_req_A),
        .next_req_cq_index     (next_req_cq_index),
        .stall_req             (stall_req),
        .req_bank0_valid       (req_bank0_valid),
        .req_bank1_valid       (req_bank1_valid),
        .req_is_mq             (req_is_mq),
        .req_misaligned        (req_misaligned),
        .req_vpn               (req_vpn),
        .req_po_word           (req_po_word),
        .req_byte_mask         (req_byte_mask),
        .req_cq_index          (req_cq_index),
        .req_bank0_early_ready (req_bank0_early_ready),
        .req_bank1_early_ready (req_bank1_early_ready)
    );

endmodule

`default_nettype wire

/* verilog/ldu_operand_collect.sv */
`timescale 1ns/10ps
`default_nettype none

module ldu_operand_collect (
    input  wire logic                          CLK,
    input  wire logic                          nRST,

    // issue queue side
    input  wire logic                          issue_valid,
    input  ldu_types_pkg::ldu_op_t             issue_op,
    input  ldu_types_pkg::imm12_t              issue_imm12,
    input  wire logic                          issue_A_forward,
    input  wire logic                          issue_A_is_zero,
    input  ldu_types_pkg::prf_bank_t           issue_A_bank,
    input  ldu_types_pkg::cq_index_t           issue_cq_index,
    output logic                               issue_ready,

    // register file read and forward data
    input  wire logic                          A_reg_read_ack,
    input  wire logic                          A_reg_read_port,
    input  ldu_types_pkg::bank_port_data_t     reg_read_data_by_bank_by_port,
    input  ldu_types_pkg::bank_data_t          forward_data_by_bank,

    // towards the request stage
    input  wire logic                          stall_req,
    output logic                               next_req_valid,
    output ldu_types_pkg::ldu_op_t             next_req_op,
    output ldu_types_pkg::imm12_t              next_req_imm12,
    output ldu_types_pkg::word_t               next_req_A,
    output ldu_types_pkg::cq_index_t           next_req_cq_index
);

    import ldu_types_pkg::*;

    // --------------------------------------------------
    // held load

    logic       valid_oc;
    ldu_op_t    op_oc;
    imm12_t     imm12_oc;
    logic       A_saved_oc;
    logic       A_forward_oc;
    logic       A_is_zero_oc;
    prf_bank_t  A_bank_oc;
    cq_index_t  cq_index_oc;
    word_t      A_saved_data_oc;

    logic       stall_oc;
    logic       A_present;
    logic       launch_ready;

    // only a held load can be stalled by REQ
    assign stall_oc = valid_oc & stall_req;

    // control flags
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_oc     <= 1'b0;
            A_saved_oc   <= 1'b0;
            A_forward_oc <= 1'b0;
            A_is_zero_oc <= 1'b0;
        end else if (!issue_ready) begin
            // operand seen while stalled is kept for later
            A_saved_oc <= A_saved_oc | A_forward_oc | A_reg_read_ack;
        end else begin
            valid_oc     <= issue_valid;
            A_saved_oc   <= 1'b0;
            A_forward_oc <= issue_A_forward;
            A_is_zero_oc <= issue_A_is_zero;
        end
    end

    // payload
    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            op_oc       <= issue_op;
            imm12_oc    <= issue_imm12;
            A_bank_oc   <= issue_A_bank;
            cq_index_oc <= issue_cq_index;
        end
        A_saved_data_oc <= next_req_A;
    end

    // --------------------------------------------------
    // operand A select

    always_comb begin
        if (A_is_zero_oc) begin
            next_req_A = '0;
        end else if (A_saved_oc) begin
            next_req_A = A_saved_data_oc;
        end else if (A_forward_oc) begin
            next_req_A = forward_data_by_bank[A_bank_oc];
        end else begin
            next_req_A = reg_read_data_by_bank_by_port[A_bank_oc][A_reg_read_port];
        end
    end

    assign A_present = A_is_zero_oc | A_saved_oc | A_forward_oc | A_reg_read_ack;

    // --------------------------------------------------
    // launch and issue feedback

    assign launch_ready = !stall_oc & A_present;
    assign issue_ready  = !valid_oc | launch_ready;

    assign next_req_valid    = valid_oc & launch_ready;
    assign next_req_op       = op_oc;
    assign next_req_imm12    = imm12_oc;
    assign next_req_cq_index = cq_index_oc;

    // register read is only granted for a load sitting in OC
    a_ack_needs_load: assert property (
        @(posedge CLK) disable iff (!nRST)
        A_reg_read_ack |-> valid_oc
    ) else $error("register read ack with OC empty");

endmodule

`default_nettype wire

/* verilog/ldu_req_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ldu_cfg.svh"

module ldu_req_stage (
    input  wire logic                      CLK,
    input  wire logic                      nRST,

    // from the operand collect stage
    input  wire logic                      next_req_valid,
    input  ldu_types_pkg::ldu_op_t         next_req_op,
    input  ldu_types_pkg::imm12_t          next_req_imm12,
    input  ldu_types_pkg::word_t           next_req_A,
    input  ldu_types_pkg::cq_index_t       next_req_cq_index,
    output logic                           stall_req,

    // dcache request
    output logic                           req_bank0_valid,
    output logic                           req_bank1_valid,
    output logic                           req_is_mq,
    output logic                           req_misaligned,
    output ldu_types_pkg::vpn_t            req_vpn,
    output ldu_types_pkg::po_word_t        req_po_word,
    output ldu_types_pkg::byte_mask_t      req_byte_mask,
    output ldu_types_pkg::cq_index_t       req_cq_index,
    input  wire logic                      req_bank0_early_ready,
    input  wire logic                      req_bank1_early_ready
);

    import ldu_types_pkg::*;

    // --------------------------------------------------
    // held load fields

    ldu_op_t    req_op;
    imm12_t     req_imm12;
    word_t      req_A;

    req_state_t state, next_state;

    word_t      va;
    word_t      va_second;
    byte_mask_t base_mask;
    logic [7:0] span_mask;
    logic       req_valid;
    logic       req_ack;

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            state <= REQ_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // payload moves in whenever REQ is free
    always_ff @(posedge CLK) begin
        if (!stall_req) begin
            req_op       <= next_req_op;
            req_imm12    <= next_req_imm12;
            req_A        <= next_req_A;
            req_cq_index <= next_req_cq_index;
        end
    end

    // --------------------------------------------------
    // address and byte mask

    assign va        = req_A + {{20{req_imm12[11]}}, req_imm12};
    // second beat goes to the next word
    assign va_second = va + 32'd4;

    always_comb begin
        if (req_op[1]) begin
            base_mask = 4'b1111;
        end else if (req_op[0]) begin
            base_mask = 4'b0011;
        end else begin
            base_mask = 4'b0001;
        end
    end

    // bytes past bit 3 belong to the next word
    assign span_mask      = {4'b0000, base_mask} << va[1:0];
    assign req_misaligned = |span_mask[7:4];

    // both dcache banks must be ready to take a beat
    assign req_ack = req_bank0_early_ready & req_bank1_early_ready;

    // --------------------------------------------------
    // beat sequencing

    always_comb begin
        next_state    = state;
        stall_req     = 1'b0;
        req_valid     = 1'b0;
        req_is_mq     = 1'b0;
        req_vpn       = va[31 -: `LDU_VPN_WIDTH];
        req_po_word   = va[`LDU_PO_WIDTH-1:2];
        req_byte_mask = span_mask[3:0];

        case (state)
            REQ_IDLE: begin
                if (next_req_valid) begin
                    next_state = REQ_ACTIVE;
                end
            end

            REQ_ACTIVE: begin
                req_valid = 1'b1;
                if (req_ack && req_misaligned) begin
                    // hold the load for its second beat
                    stall_req  = 1'b1;
                    next_state = REQ_MISALIGNED;
                end else if (req_ack) begin
                    next_state = next_req_valid ? REQ_ACTIVE : REQ_IDLE;
                end else begin
                    stall_req = 1'b1;
                end
            end

            REQ_MISALIGNED: begin
                req_valid     = 1'b1;
                req_is_mq     = 1'b1;
                req_vpn       = va_second[31 -: `LDU_VPN_WIDTH];
                req_po_word   = va_second[`LDU_PO_WIDTH-1:2];
                req_byte_mask = span_mask[7:4];
                if (req_ack) begin
                    next_state = next_req_valid ? REQ_ACTIVE : REQ_IDLE;
                end else begin
                    stall_req = 1'b1;
                end
            end

            default: begin
                next_state = REQ_IDLE;
            end
        endcase
    end

    // bank select from the word address
    assign req_bank0_valid = req_valid & !req_po_word[`LDU_DCACHE_BANK_BIT];
    assign req_bank1_valid = req_valid &  req_po_word[`LDU_DCACHE_BANK_BIT];

    // --------------------------------------------------
    // checks

    beat_holds: assert property (
        @(posedge CLK) disable iff (!nRST)
        (req_valid && !req_ack) |=>
            $stable({req_is_mq, req_vpn, req_po_word, req_byte_mask, req_cq_index})
    ) else $error("request beat changed before it was taken");

    mask_nonzero: assert property (
        @(posedge CLK) disable iff (!nRST)
        (req_bank0_valid || req_bank1_valid) |-> (req_byte_mask != '0)
    ) else $error("request beat with empty byte mask");

endmodule

`default_nettype wire

/* verilog/ldu_types_pkg.sv */
`default_nettype none

`include "ldu_cfg.svh"

package ldu_types_pkg;

    // load op encoding
    // bit 1 word, bit 0 halfword, bit 2 unsigned
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101
    } ldu_op_t;

    // request stage sequencing
    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_ACTIVE,
        REQ_MISALIGNED
    } req_state_t;

    typedef logic [31:0]                        word_t;
    typedef logic [`LDU_LOG_PRF_BANK_COUNT-1:0] prf_bank_t;
    typedef logic [`LDU_LOG_CQ_ENTRIES-1:0]     cq_index_t;
    typedef logic [`LDU_VPN_WIDTH-1:0]          vpn_t;
    typedef logic [`LDU_PO_WIDTH-3:0]           po_word_t;
    typedef logic [3:0]                         byte_mask_t;
    typedef logic [11:0]                        imm12_t;

    // forward network, one word per bank
    typedef word_t [`LDU_PRF_BANK_COUNT-1:0] bank_data_t;

    // register read network, two read ports per bank
    typedef word_t [`LDU_PRF_BANK_COUNT-1:0][1:0] bank_port_data_t;

endpackage

`default_nettype wire
